//--- source/aprBoard.sv
//////////////////////////////////////////////////////////////////////
// Processor board with a condition and a data register on the EBUS
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module aprBoard #(
  parameter int ebusWidth = ebusPkg::ebusWidth
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 sel,
  input  logic                 demand,
  input  ebusPkg::ebusFunc     func,
  input  logic [ebusWidth-1:0] dataIn,
  output logic                 driving,
  output logic [ebusWidth-1:0] data
);

  logic [ebusWidth-1:0] condReg;
  logic [ebusWidth-1:0] dataReg;
  logic                 strobe;

  assign strobe = sel & demand;

  assign driving = strobe & (func == ebusPkg::conI || func == ebusPkg::datI);
  assign data    = (func == ebusPkg::conI) ? condReg : dataReg;

  always_ff @(posedge clk) begin
    if (reset) begin
      condReg <= '0;
      dataReg <= '0;
    end else if (strobe) begin
      if (func == ebusPkg::conO) condReg <= dataIn;
      if (func == ebusPkg::datO) dataReg <= dataIn;
    end
  end

endmodule

//--- source/ebusArbiter.sv
//////////////////////////////////////////////////////////////////////
// Round-robin arbiter giving the EBUS to one of two front-end channels
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ebusArbiter (
  input  logic clk,
  input  logic reset,
  input  logic req0,
  input  logic req1,
  input  logic busDone,
  output logic grant0,
  output logic grant1
);

  logic lastWinner;                     // 1 when channel 1 won last
  logic busFree;

  assign busFree = ~grant0 & ~grant1;

  always_ff @(posedge clk) begin
    if (reset) begin
      grant0     <= 1'b0;
      grant1     <= 1'b0;
      lastWinner <= 1'b1;               // Channel 0 goes first
    end else if (busFree) begin
      if (req0 && req1) begin
        // With both asking the loser of last time gets it
        if (lastWinner) begin
          grant0     <= 1'b1;
          lastWinner <= 1'b0;
        end else begin
          grant1     <= 1'b1;
          lastWinner <= 1'b1;
        end
      end else if (req0) begin
        grant0     <= 1'b1;
        lastWinner <= 1'b0;
      end else if (req1) begin
        grant1     <= 1'b1;
        lastWinner <= 1'b1;
      end
    end else begin
      // Hold until the winner lets go and the controller is finished
      if (grant0 && !req0 && !busDone) begin
        grant0 <= 1'b0;
      end
      if (grant1 && !req1 && !busDone) begin
        grant1 <= 1'b0;
      end
    end
  end

endmodule

//--- source/ebusController.sv
//////////////////////////////////////////////////////////////////////
// Runs the granted channel's transaction on the EBUS, strobes the
// addressed board and returns the bus data with a four-phase ack
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ebusController #(
  parameter int ebusWidth = ebusPkg::ebusWidth
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   grant0,
  input  logic                   grant1,
  input  logic                   feReq0,
  input  logic                   feReq1,
  input  ebusPkg::ebusFunc       feFunc0,
  input  ebusPkg::ebusFunc       feFunc1,
  input  ebusPkg::ebusCs         feCs0,
  input  ebusPkg::ebusCs         feCs1,
  input  logic [ebusWidth-1:0]   feDataIn0,
  input  logic [ebusWidth-1:0]   feDataIn1,
  input  logic                   aprDriving,
  input  logic [ebusWidth-1:0]   aprData,
  input  logic                   picDriving,
  input  logic [ebusWidth-1:0]   picData,
  input  logic                   mtrDriving,
  input  logic [ebusWidth-1:0]   mtrData,
  output ebusPkg::ebusFunc       ebusFuncOut,
  output logic [ebusWidth-1:0]   ebusDataOut,
  output logic                   demand,
  output logic                   aprSel,
  output logic                   picSel,
  output logic                   mtrSel,
  output logic                   feAck0,
  output logic                   feAck1,
  output logic [ebusWidth-1:0]   feDataOut0,
  output logic [ebusWidth-1:0]   feDataOut1,
  output logic                   busDone
);

  typedef enum logic [1:0] {stIdle, stLatch, stStrobe, stAck} ctlState;

  ctlState              state;
  logic                 owner;          // Channel being served
  ebusPkg::ebusFunc     funcReg;
  ebusPkg::ebusCs       csReg;
  logic [ebusWidth-1:0] dataReg;
  logic [ebusWidth-1:0] busData;
  logic                 start;
  logic                 ownerReq;
  logic                 ackRelease;

  assign start      = (grant0 & feReq0) | (grant1 & feReq1);
  assign ownerReq   = owner ? feReq1 : feReq0;
  assign ackRelease = (state == stAck) & ~ownerReq;
  // Stays high through the ack phase so the arbiter keeps the grant
  assign busDone    = (state != stIdle) & ~ackRelease;

  assign ebusFuncOut = funcReg;
  assign ebusDataOut = dataReg;

  ////////////////////////////////////////////////////////////////////
  // EBUS data mux where the first driving board wins
  always_comb begin
    case (1'b1)
      aprDriving: busData = aprData;
      picDriving: busData = picData;
      mtrDriving: busData = mtrData;
      default:    busData = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // Transaction sequence
  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= stIdle;
      owner  <= 1'b0;
      demand <= 1'b0;
      aprSel <= 1'b0;
      picSel <= 1'b0;
      mtrSel <= 1'b0;
      feAck0 <= 1'b0;
      feAck1 <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          if (start) begin
            owner <= grant1;
            state <= stLatch;
          end
        end
        stLatch: begin
          // Unknown cs leaves every select low
          demand <= 1'b1;
          aprSel <= (csReg == ebusPkg::csApr);
          picSel <= (csReg == ebusPkg::csPic);
          mtrSel <= (csReg == ebusPkg::csMtr);
          state  <= stStrobe;
        end
        stStrobe: begin
          demand <= 1'b0;
          aprSel <= 1'b0;
          picSel <= 1'b0;
          mtrSel <= 1'b0;
          feAck0 <= ~owner;
          feAck1 <= owner;
          state  <= stAck;
        end
        stAck: begin
          if (ackRelease) begin
            feAck0 <= 1'b0;
            feAck1 <= 1'b0;
            state  <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

  // Request latch and read capture
  always_ff @(posedge clk) begin
    if (reset) begin
      funcReg    <= ebusPkg::conO;
      csReg      <= '0;
      dataReg    <= '0;
      feDataOut0 <= '0;
      feDataOut1 <= '0;
    end else begin
      if (state == stIdle && start) begin
        funcReg <= grant1 ? feFunc1 : feFunc0;
        csReg   <= grant1 ? feCs1 : feCs0;
        dataReg <= grant1 ? feDataIn1 : feDataIn0;
      end
      if (state == stStrobe) begin
        if (owner) feDataOut1 <= busData;
        else       feDataOut0 <= busData;
      end
    end
  end

endmodule

//--- source/ebusPkg.sv
//////////////////////////////////////////////////////////////////////
// EBUS function codes, board select codes and default widths shared
// by the arbiter, the controller, the boards and the testbench
//////////////////////////////////////////////////////////////////////
package ebusPkg;

  // EBUS function field
  typedef enum logic [1:0] {
    conO = 2'd0,                        // Write control
    conI = 2'd1,                        // Read status
    datO = 2'd2,                        // Write data
    datI = 2'd3                         // Read data
  } ebusFunc;

  // Controller select code
  typedef logic [2:0] ebusCs;

  localparam ebusCs csApr = 3'd0;
  localparam ebusCs csPic = 3'd1;
  localparam ebusCs csMtr = 3'd2;

  // Default EBUS word width
  localparam int ebusWidth = 36;

  // Interrupt levels 1 to 7
  localparam int piLevels = 7;

  // Default meter counter width
  localparam int meterWidth = 24;

endpackage

//--- source/ebusSubsystem.sv
//////////////////////////////////////////////////////////////////////
// EBUS slice top level; two front-end channels, arbiter, controller
// and the apr, pic and mtr boards
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ebusSubsystem #(
  parameter int ebusWidth  = ebusPkg::ebusWidth,
  parameter int meterWidth = ebusPkg::meterWidth
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [ebusPkg::piLevels-1:0]  irq,
  input  logic                          feReq0,
  input  ebusPkg::ebusFunc              feFunc0,
  input  ebusPkg::ebusCs                feCs0,
  input  logic [ebusWidth-1:0]          feDataIn0,
  output logic                          feAck0,
  output logic [ebusWidth-1:0]          feDataOut0,
  input  logic                          feReq1,
  input  ebusPkg::ebusFunc              feFunc1,
  input  ebusPkg::ebusCs                feCs1,
  input  logic [ebusWidth-1:0]          feDataIn1,
  output logic                          feAck1,
  output logic [ebusWidth-1:0]          feDataOut1
);

  logic grant0, grant1, busDone;

  // Common EBUS lines
  ebusPkg::ebusFunc     ebusFunc;
  logic [ebusWidth-1:0] ebusData;
  logic                 demand;
  logic                 aprSel, picSel, mtrSel;

  // Board drivers
  logic                 aprDriving, picDriving, mtrDriving;
  logic [ebusWidth-1:0] aprData, picData, mtrData;

  ebusArbiter i_ebusArbiter (
    .clk(clk), .reset(reset), .req0(feReq0), .req1(feReq1),
    .busDone(busDone), .grant0(grant0), .grant1(grant1)
  );

  ebusController #(.ebusWidth(ebusWidth)) i_ebusController (
    .clk(clk), .reset(reset), .grant0(grant0), .grant1(grant1),
    .feReq0(feReq0), .feReq1(feReq1), .feFunc0(feFunc0), .feFunc1(feFunc1),
    .feCs0(feCs0), .feCs1(feCs1), .feDataIn0(feDataIn0), .feDataIn1(feDataIn1),
    .aprDriving(aprDriving), .aprData(aprData), .picDriving(picDriving),
    .picData(picData), .mtrDriving(mtrDriving), .mtrData(mtrData),
    .ebusFuncOut(ebusFunc), .ebusDataOut(ebusData), .demand(demand),
    .aprSel(aprSel), .picSel(picSel), .mtrSel(mtrSel),
    .feAck0(feAck0), .feAck1(feAck1), .feDataOut0(feDataOut0),
    .feDataOut1(feDataOut1), .busDone(busDone)
  );

  aprBoard #(.ebusWidth(ebusWidth)) i_aprBoard (
    .clk(clk), .reset(reset), .sel(aprSel), .demand(demand), .func(ebusFunc),
    .dataIn(ebusData), .driving(aprDriving), .data(aprData)
  );

  picBoard #(.ebusWidth(ebusWidth)) i_picBoard (
    .clk(clk), .reset(reset), .sel(picSel), .demand(demand), .func(ebusFunc),
    .dataIn(ebusData), .irq(irq), .driving(picDriving), .data(picData)
  );

  mtrBoard #(.ebusWidth(ebusWidth), .meterWidth(meterWidth)) i_mtrBoard (
    .clk(clk), .reset(reset), .sel(mtrSel), .demand(demand), .func(ebusFunc),
    .dataIn(ebusData), .driving(mtrDriving), .data(mtrData)
  );

endmodule

//--- source/mtrBoard.sv
//////////////////////////////////////////////////////////////////////
// Meter board; a time-base counter that counts clocks while enabled
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module mtrBoard #(
  parameter int ebusWidth  = ebusPkg::ebusWidth,
  parameter int meterWidth = ebusPkg::meterWidth
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 sel,
  input  logic                 demand,
  input  ebusPkg::ebusFunc     func,
  input  logic [ebusWidth-1:0] dataIn,
  output logic                 driving,
  output logic [ebusWidth-1:0] data
);

  logic                  enable;
  logic [meterWidth-1:0] count;
  logic                  conWrite;

  assign conWrite = sel & demand & (func == ebusPkg::conO);

  assign driving = sel & demand & (func == ebusPkg::conI || func == ebusPkg::datI);
  assign data    = (func == ebusPkg::conI) ? ebusWidth'(enable) : ebusWidth'(count);

  always_ff @(posedge clk) begin
    if (reset) begin
      enable <= 1'b0;
      count  <= '0;
    end else begin
      if (conWrite) enable <= dataIn[0];
      if (conWrite && dataIn[1]) count <= '0;   // Clear beats counting
      else if (enable)           count <= count + 1'b1;
    end
  end

endmodule

//--- source/picBoard.sv
//////////////////////////////////////////////////////////////////////
// Priority interrupt board; request bit n-1 holds level n, and level 1
// is the highest. Requests come from conO and the external irq lines
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module picBoard #(
  parameter int ebusWidth = ebusPkg::ebusWidth
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sel,
  input  logic                          demand,
  input  ebusPkg::ebusFunc              func,
  input  logic [ebusWidth-1:0]          dataIn,
  input  logic [ebusPkg::piLevels-1:0]  irq,
  output logic                          driving,
  output logic [ebusWidth-1:0]          data
);

  localparam int levelBits = $clog2(ebusPkg::piLevels + 1);

  logic [ebusPkg::piLevels-1:0] reqBits;
  logic [ebusPkg::piLevels-1:0] mask;
  logic [levelBits-1:0]         highest;   // 0 when nothing pending
  logic                         conWrite;

  assign mask     = dataIn[ebusPkg::piLevels-1:0];
  assign conWrite = sel & demand & (func == ebusPkg::conO);

  // Lowest index found last so level 1 wins
  always_comb begin
    highest = '0;
    for (int i = ebusPkg::piLevels - 1; i >= 0; i--) begin
      if (reqBits[i]) highest = levelBits'(i + 1);
    end
  end

  assign driving = sel & demand & (func == ebusPkg::conI || func == ebusPkg::datI);
  assign data    = (func == ebusPkg::conI) ? ebusWidth'({highest, 1'b0, reqBits}) : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      reqBits <= '0;
    end else begin
      if (conWrite && dataIn[7]) begin
        reqBits <= reqBits | mask | irq;  // Set wins over clear
      end else if (conWrite && dataIn[8]) begin
        reqBits <= (reqBits & ~mask) | irq;
      end else begin
        reqBits <= reqBits | irq;
      end
    end
  end

endmodule

//--- src.f
source/ebusPkg.sv
source/ebusArbiter.sv
source/ebusController.sv
source/aprBoard.sv
source/picBoard.sv
source/mtrBoard.sv
source/ebusSubsystem.sv
testbench/ebusSubsystemTb.sv

//--- testbench/ebusSubsystemTb.sv
//////////////////////////////////////////////////////////////////////
// Directed testbench for the EBUS slice; drives both front-end channels
// through every board and checks arbitration under contention
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module ebusSubsystemTb;

  localparam int ebusWidth   = ebusPkg::ebusWidth;
  localparam int meterWidth  = ebusPkg::meterWidth;
  localparam int piLevels    = ebusPkg::piLevels;
  localparam int resetCycles = 10;
  localparam int txnCycles   = 8;       // Idle-bus transaction is about 6
  localparam int txnCount    = 40;
  localparam int cycleLimit  = resetCycles + txnCount * txnCycles;
  localparam logic [63:0] wordMask = (64'd1 << ebusWidth) - 1;

  logic                 clk = 1'b0;
  logic                 reset;
  logic [piLevels-1:0]  irq;
  logic                 feReq0, feReq1;
  ebusPkg::ebusFunc     feFunc0, feFunc1;
  ebusPkg::ebusCs       feCs0, feCs1;
  logic [ebusWidth-1:0] feDataIn0, feDataIn1;
  logic                 feAck0, feAck1;
  logic [ebusWidth-1:0] feDataOut0, feDataOut1;

  logic [31:0] rngState = 32'h39fa;
  int          cycleCount = 0;
  int          errorCount = 0;
  int          lastServed = 1;           // Arbiter favours channel 0 after reset
  int          winnerA;
  int          winnerB;

  ebusSubsystem #(.ebusWidth(ebusWidth), .meterWidth(meterWidth)) i_ebusSubsystem (
    .clk(clk), .reset(reset), .irq(irq),
    .feReq0(feReq0), .feFunc0(feFunc0), .feCs0(feCs0), .feDataIn0(feDataIn0),
    .feAck0(feAck0), .feDataOut0(feDataOut0),
    .feReq1(feReq1), .feFunc1(feFunc1), .feCs1(feCs1), .feDataIn1(feDataIn1),
    .feAck1(feAck1), .feDataOut1(feDataOut1)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Run timed out after %0d cycles without finishing", cycleCount);
      $display("Checks failed");
      $fatal(1, "Cycle limit reached");
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] expected);
    if (got !== expected) begin
      errorCount++;
      $display("ERR %s got %h expected %h", name, got, expected);
      $display("Checks failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic randomWord(output logic [63:0] word);
    logic [31:0] high;
    rngState = xorshift(rngState);
    high     = rngState;
    rngState = xorshift(rngState);
    word     = {high, rngState};
  endtask

  function automatic logic ackOf(input int ch);
    return (ch == 0) ? feAck0 : feAck1;
  endfunction

  // Expected conI word with request bits low and first pending level in 10:8
  function automatic logic [63:0] picStatus(input logic [piLevels-1:0] bits);
    logic [2:0] level;
    level = 3'd0;
    for (int n = 1; n <= piLevels; n++) begin
      if (bits[n-1] && level == 3'd0) level = 3'(n);
    end
    return 64'({level, 1'b0, bits});
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Four-phase channel cycle
  task automatic feTransaction(
    input  int                   ch,
    input  ebusPkg::ebusFunc     func,
    input  ebusPkg::ebusCs       cs,
    input  logic [ebusWidth-1:0] wdata,
    output logic [ebusWidth-1:0] rdata,
    output int                   ackCycles,
    output int                   dropCycles
  );
    @(negedge clk);
    if (ch == 0) begin
      feFunc0   = func;
      feCs0     = cs;
      feDataIn0 = wdata;
      feReq0    = 1'b1;
    end else begin
      feFunc1   = func;
      feCs1     = cs;
      feDataIn1 = wdata;
      feReq1    = 1'b1;
    end
    @(negedge clk);
    ackCycles = 1;
    while (!ackOf(ch)) begin
      @(negedge clk);
      ackCycles++;
    end
    rdata = (ch == 0) ? feDataOut0 : feDataOut1;
    if (ch == 0) feReq0 = 1'b0;
    else         feReq1 = 1'b0;
    dropCycles = 0;
    while (ackOf(ch)) begin
      @(negedge clk);
      dropCycles++;
    end
    lastServed = ch;
  endtask

  task automatic busWrite(input int ch, input ebusPkg::ebusFunc func,
                          input ebusPkg::ebusCs cs, input logic [63:0] wdata);
    logic [ebusWidth-1:0] readBack;
    int                   ackCycles;
    int                   dropCycles;
    feTransaction(ch, func, cs, ebusWidth'(wdata), readBack, ackCycles, dropCycles);
  endtask

  task automatic busRead(input int ch, input ebusPkg::ebusFunc func,
                         input ebusPkg::ebusCs cs, output logic [63:0] rdata);
    logic [ebusWidth-1:0] word;
    int                   ackCycles;
    int                   dropCycles;
    feTransaction(ch, func, cs, '0, word, ackCycles, dropCycles);
    rdata = 64'(word);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  task automatic handshakeTiming();
    logic [ebusWidth-1:0] word;
    int                   ackCycles;
    int                   dropCycles;
    check("feAck0", 64'(feAck0), 64'd0);
    check("feAck1", 64'(feAck1), 64'd0);
    for (int ch = 0; ch < 2; ch++) begin
      feTransaction(ch, ebusPkg::datI, ebusPkg::csApr, '0, word, ackCycles, dropCycles);
      check("ackLatency", 64'(ackCycles), 64'd4);
      check("ackRelease", 64'(dropCycles), 64'd1);
    end
  endtask

  task automatic aprReadBack(input int ch);
    logic [63:0] condWord;
    logic [63:0] dataWord;
    logic [63:0] got;
    randomWord(condWord);
    randomWord(dataWord);
    busWrite(ch, ebusPkg::conO, ebusPkg::csApr, condWord);
    busWrite(ch, ebusPkg::datO, ebusPkg::csApr, dataWord);
    busRead(ch, ebusPkg::conI, ebusPkg::csApr, got);
    check("aprCond", got, condWord & wordMask);
    busRead(ch, ebusPkg::datI, ebusPkg::csApr, got);
    check("aprData", got, dataWord & wordMask);
    busRead(ch, ebusPkg::datI, 3'd5, got);  // No board answers
    check("unknownCs", got, 64'd0);
  endtask

  task automatic picSetClear();
    logic [piLevels-1:0] model;
    logic [63:0]         got;
    model = 7'b0010100;                 // Levels 3 and 5
    busWrite(0, ebusPkg::conO, ebusPkg::csPic, 64'h80 | 64'(model));
    busRead(0, ebusPkg::conI, ebusPkg::csPic, got);
    check("picStatus", got, picStatus(model));
    busWrite(1, ebusPkg::conO, ebusPkg::csPic, 64'h104);
    model = model & ~7'b0000100;
    busRead(1, ebusPkg::conI, ebusPkg::csPic, got);
    check("picStatus", got, picStatus(model));
    @(negedge clk);
    irq = 7'b0000010;                   // Level 2 from outside
    @(negedge clk);
    irq = '0;
    model = model | 7'b0000010;
    busRead(0, ebusPkg::conI, ebusPkg::csPic, got);
    check("picStatus", got, picStatus(model));
    busRead(0, ebusPkg::datI, ebusPkg::csPic, got);
    check("picData", got, 64'd0);
  endtask

  task automatic meterCount();
    logic [63:0] earlyCount;
    logic [63:0] lateCount;
    logic [63:0] got;
    busWrite(0, ebusPkg::conO, ebusPkg::csMtr, 64'h1);  // Let it count first
    busWrite(0, ebusPkg::conO, ebusPkg::csMtr, 64'h2);  // Clear and disable
    busRead(0, ebusPkg::datI, ebusPkg::csMtr, got);
    check("mtrCount", got, 64'd0);
    busRead(1, ebusPkg::datI, ebusPkg::csMtr, got);
    check("mtrCount", got, 64'd0);
    busWrite(1, ebusPkg::conO, ebusPkg::csMtr, 64'h1);
    busRead(0, ebusPkg::datI, ebusPkg::csMtr, earlyCount);
    busRead(1, ebusPkg::datI, ebusPkg::csMtr, lateCount);
    check("mtrNonzero", 64'(earlyCount != 0), 64'd1);
    check("mtrIncreasing", 64'(lateCount > earlyCount), 64'd1);
    busRead(0, ebusPkg::conI, ebusPkg::csMtr, got);
    check("mtrEnable", got, 64'd1);
  endtask

  task automatic contention(input int prevWinner, output int winner);
    logic [63:0] word0;
    logic [63:0] word1;
    logic [63:0] got;
    logic        done0;
    logic        done1;
    int          expectedWinner;
    int          second;
    randomWord(word0);
    randomWord(word1);
    expectedWinner = (lastServed == 0) ? 1 : 0;
    winner = -1;
    done0  = 1'b0;
    done1  = 1'b0;
    @(negedge clk);
    feFunc0   = ebusPkg::datO;
    feCs0     = ebusPkg::csApr;
    feDataIn0 = ebusWidth'(word0);
    feFunc1   = ebusPkg::datO;
    feCs1     = ebusPkg::csApr;
    feDataIn1 = ebusWidth'(word1);
    feReq0    = 1'b1;
    feReq1    = 1'b1;
    while (!(done0 && done1 && !feAck0 && !feAck1)) begin
      @(negedge clk);
      check("ackOverlap", 64'(feAck0 & feAck1), 64'd0);
      if (feAck0 && feReq0) begin
        if (winner < 0) winner = 0;
        feReq0 = 1'b0;
        done0  = 1'b1;
      end
      if (feAck1 && feReq1) begin
        if (winner < 0) winner = 1;
        feReq1 = 1'b0;
        done1  = 1'b1;
      end
    end
    second     = 1 - winner;
    lastServed = second;
    check("firstGrant", 64'(winner), 64'(expectedWinner));
    if (prevWinner >= 0) check("grantAlternates", 64'(winner), 64'(1 - prevWinner));
    // Reading on the first winner hands the next contention to the other channel
    busRead(winner, ebusPkg::datI, ebusPkg::csApr, got);
    check("aprContention", got, ((second == 0) ? word0 : word1) & wordMask);
  endtask

  //////////////////////////////////////////////////////////////////////
  initial begin
    reset     = 1'b1;
    irq       = '0;
    feReq0    = 1'b0;
    feFunc0   = ebusPkg::conO;
    feCs0     = ebusPkg::csApr;
    feDataIn0 = '0;
    feReq1    = 1'b0;
    feFunc1   = ebusPkg::conO;
    feCs1     = ebusPkg::csApr;
    feDataIn1 = '0;
    repeat (resetCycles) @(negedge clk);
    reset = 1'b0;

    handshakeTiming();
    aprReadBack(0);
    aprReadBack(1);
    picSetClear();
    meterCount();
    contention(-1, winnerA);
    contention(winnerA, winnerB);

    if (errorCount == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
